// File: src.f
wb_ic_pkg.sv
wb_ic_decoder.sv
wb_ic_arbiter.sv
wb_ic_resp_mux.sv
wb_ic_ram.sv
wb_ic_top.sv
tb_wb_ic_asserts.sv
tb_wb_ic.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_wb_ic
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_wb_ic.sv
/*
 * Directed testbench for the two-master Wishbone interconnect.
 * Drives both master ports, keeps a RAM model per target and checks
 * every response against it. Built and run through the Makefile.
 */
module tb_wb_ic;
	timeunit 1ns;
	timeprecision 1ps;
	import wb_ic_pkg::*;

	localparam logic [1:0] RESP_NONE = 2'b00;
	localparam logic [1:0] RESP_ACK = 2'b01;
	localparam logic [1:0] RESP_ERR = 2'b10;
	localparam int TIMEOUT = 50;

	logic              clk;
	logic              rstn;
	logic              m_cyc  [N_MASTERS];
	logic              m_stb  [N_MASTERS];
	logic              m_we   [N_MASTERS];
	logic [ADDR_W-1:0] m_adr  [N_MASTERS];
	logic [DATA_W-1:0] m_wdat [N_MASTERS];
	logic [SEL_W-1:0]  m_sel  [N_MASTERS];
	logic              m_ack  [N_MASTERS];
	logic              m_err  [N_MASTERS];
	logic [DATA_W-1:0] m_rdat [N_MASTERS];

	// Expected RAM contents by window index and word
	logic [DATA_W-1:0] model [N_TARGETS][RAM_WORDS];
	int                done_log [$];
	int                seed = 38242;

	wb_ic_top dut0 (
		.clk     (clk),
		.rstn    (rstn),
		.m_cyc_i (m_cyc),
		.m_stb_i (m_stb),
		.m_we_i  (m_we),
		.m_adr_i (m_adr),
		.m_dat_i (m_wdat),
		.m_sel_i (m_sel),
		.m_ack_o (m_ack),
		.m_err_o (m_err),
		.m_dat_o (m_rdat)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_fail();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_text(input string msg);
		$display("%s", msg);
		stop_fail();
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			stop_fail();
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			stop_fail();
		end
	endtask

	task automatic idle_master(input int m);
		m_cyc[m] = 1'b0;
		m_stb[m] = 1'b0;
		m_we[m] = 1'b0;
		m_adr[m] = '0;
		m_wdat[m] = '0;
		m_sel[m] = '0;
	endtask

	function automatic logic [ADDR_W-1:0] make_adr(input int t, input int w);
		logic [ADDR_W-1:0] adr;
		adr = ADDR_W'(t) << TGT_WIN_BITS;
		adr[RAM_AW+1:2] = RAM_AW'(w);
		return adr;
	endfunction

	task automatic model_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
			input logic [SEL_W-1:0] sel);
		int t;
		int w;
		t = int'(adr[ADDR_W-1:TGT_WIN_BITS]);
		w = int'(adr[RAM_AW+1:2]);
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				model[t][w][8*b +: 8] = dat[8*b +: 8];
			end
		end
	endtask

	function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] adr);
		return model[int'(adr[ADDR_W-1:TGT_WIN_BITS])][int'(adr[RAM_AW+1:2])];
	endfunction

	// One classic cycle, held until ack or err is seen at a falling edge
	task automatic bus_cycle(input int m, input logic we, input logic [ADDR_W-1:0] adr,
			input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
			output logic [1:0] resp, output logic [DATA_W-1:0] rdat);
		int n;
		@(posedge clk);
		#2;
		m_cyc[m] = 1'b1;
		m_stb[m] = 1'b1;
		m_we[m] = we;
		m_adr[m] = adr;
		m_wdat[m] = dat;
		m_sel[m] = sel;
		n = 0;
		resp = RESP_NONE;
		rdat = '0;
		while (resp == RESP_NONE) begin
			@(negedge clk);
			resp = {m_err[m], m_ack[m]};
			rdat = m_rdat[m];
			n++;
			if (resp == RESP_NONE && n >= TIMEOUT) begin
				report_text($sformatf("Master %0d got no ack or err in time", m));
			end
		end
		if (resp == RESP_ACK) begin
			done_log.push_back(m);
		end
		@(posedge clk);
		#2;
		idle_master(m);
	endtask

	task automatic wb_write(input int m, input logic [ADDR_W-1:0] adr,
			input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel, output logic [1:0] resp);
		logic [DATA_W-1:0] unused;
		bus_cycle(m, 1'b1, adr, dat, sel, resp, unused);
	endtask

	task automatic wb_read(input int m, input logic [ADDR_W-1:0] adr,
			output logic [1:0] resp, output logic [DATA_W-1:0] rdat);
		bus_cycle(m, 1'b0, adr, '0, '1, resp, rdat);
	endtask

	// Written word must come back from the model through the read path
	task automatic write_read(input int m, input logic [ADDR_W-1:0] adr,
			input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel);
		logic [1:0]        resp;
		logic [DATA_W-1:0] rdat;
		wb_write(m, adr, dat, sel, resp);
		check_resp("{m_err_o,m_ack_o} on write", resp, RESP_ACK);
		model_write(adr, dat, sel);
		wb_read(m, adr, resp, rdat);
		check_resp("{m_err_o,m_ack_o} on read", resp, RESP_ACK);
		check_data("m_dat_o", rdat, model_read(adr));
	endtask

	task automatic check_quiet();
		for (int m = 0; m < N_MASTERS; m++) begin
			check_resp($sformatf("{m_err_o,m_ack_o}[%0d]", m), {m_err[m], m_ack[m]}, RESP_NONE);
			check_data($sformatf("m_dat_o[%0d]", m), m_rdat[m], '0);
		end
	endtask

	task automatic reset_values();
		rstn = 1'b0;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			check_quiet();
		end
		@(posedge clk);
		#2;
		rstn = 1'b1;
		@(negedge clk);
		check_quiet();
	endtask

	task automatic word_access();
		for (int t = 0; t < N_TARGETS; t++) begin
			for (int i = 0; i < 4; i++) begin
				write_read(0, make_adr(t, $random(seed) & (RAM_WORDS - 1)), $random(seed), '1);
			end
		end
	endtask

	task automatic byte_lane_writes();
		logic [SEL_W-1:0]  lanes [3] = '{4'b0001, 4'b0110, 4'b1000};
		logic [ADDR_W-1:0] adr;
		adr = make_adr(1, 4);
		write_read(0, adr, $random(seed), '1);
		for (int i = 0; i < 3; i++) begin
			write_read(0, adr, $random(seed), lanes[i]);
		end
	endtask

	task automatic unmapped_access();
		logic [1:0]        resp;
		logic [DATA_W-1:0] rdat;
		write_read(0, make_adr(0, 8), $random(seed), '1);
		write_read(0, make_adr(1, 8), $random(seed), '1);
		bus_cycle(0, 1'b1, make_adr(2, 8), $random(seed), '1, resp, rdat);
		check_resp("{m_err_o,m_ack_o} on unmapped write", resp, RESP_ERR);
		check_data("unmapped m_dat_o", rdat, '0);
		wb_read(1, 16'hFFFC, resp, rdat);
		check_resp("{m_err_o,m_ack_o} on unmapped read", resp, RESP_ERR);
		check_data("unmapped m_dat_o", rdat, '0);
		for (int t = 0; t < N_TARGETS; t++) begin
			wb_read(0, make_adr(t, 8), resp, rdat);
			check_data("m_dat_o", rdat, model_read(make_adr(t, 8)));
		end
	endtask

	task automatic contended_writes();
		logic [1:0]        r0;
		logic [1:0]        r1;
		logic [DATA_W-1:0] d0;
		logic [DATA_W-1:0] d1;
		done_log.delete();
		for (int i = 0; i < 4; i++) begin
			// A lone access by one master puts the other one next in line
			d0 = $random(seed);
			wb_write(i % 2, make_adr(0, 48 + i), d0, '1, r0);
			check_resp("{m_err_o,m_ack_o} on lone write", r0, RESP_ACK);
			model_write(make_adr(0, 48 + i), d0, '1);
			d0 = $random(seed);
			d1 = $random(seed);
			fork
				wb_write(0, make_adr(0, 16 + i), d0, '1, r0);
				wb_write(1, make_adr(0, 32 + i), d1, '1, r1);
			join
			check_resp("{m_err_o,m_ack_o}[0] on write", r0, RESP_ACK);
			check_resp("{m_err_o,m_ack_o}[1] on write", r1, RESP_ACK);
			model_write(make_adr(0, 16 + i), d0, '1);
			model_write(make_adr(0, 32 + i), d1, '1);
		end
		if (done_log.size() != 12) begin
			report_text("Contended writes did not all complete");
		end
		for (int i = 1; i < done_log.size(); i++) begin
			if (done_log[i] == done_log[i-1]) begin
				report_text("Round-robin grant order did not alternate");
			end
		end
		for (int i = 0; i < 4; i++) begin
			wb_read(1, make_adr(0, 16 + i), r0, d0);
			check_data("m_dat_o", d0, model_read(make_adr(0, 16 + i)));
			wb_read(0, make_adr(0, 32 + i), r1, d1);
			check_data("m_dat_o", d1, model_read(make_adr(0, 32 + i)));
		end
	endtask

	task automatic parallel_access();
		logic [1:0]        r0;
		logic [1:0]        r1;
		logic [DATA_W-1:0] d0;
		logic [DATA_W-1:0] d1;
		d0 = $random(seed);
		d1 = $random(seed);
		fork
			wb_write(0, make_adr(0, 40), d0, '1, r0);
			wb_write(1, make_adr(1, 40), d1, '1, r1);
		join
		check_resp("{m_err_o,m_ack_o}[0] on write", r0, RESP_ACK);
		check_resp("{m_err_o,m_ack_o}[1] on write", r1, RESP_ACK);
		model_write(make_adr(0, 40), d0, '1);
		model_write(make_adr(1, 40), d1, '1);
		fork
			wb_read(0, make_adr(0, 40), r0, d0);
			wb_read(1, make_adr(1, 40), r1, d1);
		join
		check_resp("{m_err_o,m_ack_o}[0] on read", r0, RESP_ACK);
		check_resp("{m_err_o,m_ack_o}[1] on read", r1, RESP_ACK);
		check_data("m_dat_o[0]", d0, model_read(make_adr(0, 40)));
		check_data("m_dat_o[1]", d1, model_read(make_adr(1, 40)));
	endtask

	initial begin
		int fails;
		rstn = 1'b0;
		for (int m = 0; m < N_MASTERS; m++) begin
			idle_master(m);
		end
		reset_values();
		word_access();
		byte_lane_writes();
		unmapped_access();
		contended_writes();
		parallel_access();
		repeat (2) @(posedge clk);
		fails = dut0.u_asserts.n_excl + dut0.u_asserts.n_stb + dut0.u_asserts.n_ack2;
		if (fails != 0) begin
			report_text("Protocol assertions failed on the master ports");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

// File: tb_wb_ic_asserts.sv
/*
 * Wishbone response checks on the interconnect's master ports.
 * Bound into wb_ic_top, the testbench reads back the failure counts.
 */
module tb_wb_ic_asserts (
	input logic clk,
	input logic rstn,
	input logic m_stb_i [wb_ic_pkg::N_MASTERS],
	input logic m_ack_o [wb_ic_pkg::N_MASTERS],
	input logic m_err_o [wb_ic_pkg::N_MASTERS]
);
	timeunit 1ns;
	timeprecision 1ps;
	import wb_ic_pkg::*;

	logic [N_MASTERS-1:0] stb_v;
	logic [N_MASTERS-1:0] ack_v;
	logic [N_MASTERS-1:0] err_v;
	int                   n_excl = 0;
	int                   n_stb = 0;
	int                   n_ack2 = 0;

	always_comb begin
		for (int m = 0; m < N_MASTERS; m++) begin
			stb_v[m] = m_stb_i[m];
			ack_v[m] = m_ack_o[m];
			err_v[m] = m_err_o[m];
		end
	end

	a_excl: assert property (@(posedge clk) disable iff (!rstn) (ack_v & err_v) == '0)
		else begin
			n_excl <= n_excl + 1;
			$error("ack and err high together");
		end

	// A response belongs to a live strobe
	a_stb: assert property (@(posedge clk) disable iff (!rstn) ((ack_v | err_v) & ~stb_v) == '0)
		else begin
			n_stb <= n_stb + 1;
			$error("response without stb");
		end

	a_ack2: assert property (@(posedge clk) disable iff (!rstn) (ack_v & $past(ack_v)) == '0)
		else begin
			n_ack2 <= n_ack2 + 1;
			$error("ack held for two cycles");
		end

endmodule

bind wb_ic_top tb_wb_ic_asserts u_asserts (
	.clk     (clk),
	.rstn    (rstn),
	.m_stb_i (m_stb_i),
	.m_ack_o (m_ack_o),
	.m_err_o (m_err_o)
);

// File: wb_ic_top.sv
/*
 * Two-master, two-RAM Wishbone classic interconnect.
 * Masters connect on the m_* ports, RAMs are internal at 0x0000 and 0x1000.
 */
module wb_ic_top (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          m_cyc_i [wb_ic_pkg::N_MASTERS],
	input  logic                          m_stb_i [wb_ic_pkg::N_MASTERS],
	input  logic                          m_we_i  [wb_ic_pkg::N_MASTERS],
	input  logic [wb_ic_pkg::ADDR_W-1:0]  m_adr_i [wb_ic_pkg::N_MASTERS],
	input  logic [wb_ic_pkg::DATA_W-1:0]  m_dat_i [wb_ic_pkg::N_MASTERS],
	input  logic [wb_ic_pkg::SEL_W-1:0]   m_sel_i [wb_ic_pkg::N_MASTERS],
	output logic                          m_ack_o [wb_ic_pkg::N_MASTERS],
	output logic                          m_err_o [wb_ic_pkg::N_MASTERS],
	output logic [wb_ic_pkg::DATA_W-1:0]  m_dat_o [wb_ic_pkg::N_MASTERS]
);
	import wb_ic_pkg::*;

	tgt_id_t           sel_tgt   [N_MASTERS];
	logic              dec_busy  [N_MASTERS];
	logic              done      [N_MASTERS];
	wire               gnt_valid [N_TARGETS];
	wire mst_id_t      gnt_id    [N_TARGETS];
	wire               t_ack     [N_TARGETS];
	wire [DATA_W-1:0]  t_dat_r   [N_TARGETS];

	// A master's cycle ends on either response
	always_comb begin
		for (int m = 0; m < N_MASTERS; m++) begin
			done[m] = m_ack_o[m] | m_err_o[m];
		end
	end

	wb_ic_decoder u_dec (
		.clk       (clk),
		.rstn      (rstn),
		.cyc_i     (m_cyc_i),
		.stb_i     (m_stb_i),
		.adr_i     (m_adr_i),
		.done_i    (done),
		.sel_tgt_o (sel_tgt),
		.busy_o    (dec_busy)
	);

	for (genvar t = 0; t < N_TARGETS; t++) begin : g_tgt
		logic [N_MASTERS-1:0] req;
		logic                 t_cyc;
		logic                 t_stb;
		logic                 t_we;
		logic [ADDR_W-1:0]    t_adr;
		logic [DATA_W-1:0]    t_dat_w;
		logic [SEL_W-1:0]     t_sel;

		always_comb begin
			for (int m = 0; m < N_MASTERS; m++) begin
				req[m] = (sel_tgt[m] == tgt_id_t'(t));
			end
		end

		wb_ic_arbiter u_arb (
			.clk         (clk),
			.rstn        (rstn),
			.req_i       (req),
			.m_cyc_i     (m_cyc_i),
			.m_stb_i     (m_stb_i),
			.m_we_i      (m_we_i),
			.m_adr_i     (m_adr_i),
			.m_dat_i     (m_dat_i),
			.m_sel_i     (m_sel_i),
			.t_cyc_o     (t_cyc),
			.t_stb_o     (t_stb),
			.t_we_o      (t_we),
			.t_adr_o     (t_adr),
			.t_dat_o     (t_dat_w),
			.t_sel_o     (t_sel),
			.gnt_valid_o (gnt_valid[t]),
			.gnt_id_o    (gnt_id[t])
		);

		wb_ic_ram u_ram (
			.clk   (clk),
			.rstn  (rstn),
			.cyc_i (t_cyc),
			.stb_i (t_stb),
			.we_i  (t_we),
			.adr_i (t_adr),
			.dat_i (t_dat_w),
			.sel_i (t_sel),
			.ack_o (t_ack[t]),
			.dat_o (t_dat_r[t])
		);
	end

	wb_ic_resp_mux u_resp (
		.clk         (clk),
		.rstn        (rstn),
		.sel_tgt_i   (sel_tgt),
		.busy_i      (dec_busy),
		.gnt_valid_i (gnt_valid),
		.gnt_id_i    (gnt_id),
		.t_ack_i     (t_ack),
		.t_dat_i     (t_dat_r),
		.m_ack_o     (m_ack_o),
		.m_err_o     (m_err_o),
		.m_dat_o     (m_dat_o)
	);

endmodule

// File: wb_ic_ram.sv
/*
 * Word RAM on a Wishbone classic target port. Byte selects mask writes,
 * read data is registered and ack is a single-cycle pulse.
 */
module wb_ic_ram (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          cyc_i,
	input  logic                          stb_i,
	input  logic                          we_i,
	input  logic [wb_ic_pkg::ADDR_W-1:0]  adr_i,
	input  logic [wb_ic_pkg::DATA_W-1:0]  dat_i,
	input  logic [wb_ic_pkg::SEL_W-1:0]   sel_i,
	output logic                          ack_o,
	output logic [wb_ic_pkg::DATA_W-1:0]  dat_o
);
	import wb_ic_pkg::*;

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [RAM_AW-1:0] word;
	logic              acc;

	// Upper window bits alias onto the same words
	assign word = adr_i[RAM_AW+1:2];

	// Hold off while ack is out so one strobe gives one access
	assign acc = cyc_i && stb_i && !ack_o;

	always_ff @(posedge clk) begin
		if (acc && we_i) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (sel_i[b]) begin
					mem[word][8*b +: 8] <= dat_i[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (acc && !we_i) begin
			dat_o <= mem[word];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= acc;
		end
	end

endmodule

// File: wb_ic_resp_mux.sv
/*
 * Response path back to the masters. Routes ack and read data from the
 * selected target to the master holding its grant, and answers unmapped
 * cycles with a one-cycle err.
 */
module wb_ic_resp_mux (
	input  logic                          clk,
	input  logic                          rstn,
	input  wb_ic_pkg::tgt_id_t            sel_tgt_i   [wb_ic_pkg::N_MASTERS],
	input  logic                          busy_i      [wb_ic_pkg::N_MASTERS],
	input  logic                          gnt_valid_i [wb_ic_pkg::N_TARGETS],
	input  wb_ic_pkg::mst_id_t            gnt_id_i    [wb_ic_pkg::N_TARGETS],
	input  logic                          t_ack_i     [wb_ic_pkg::N_TARGETS],
	input  logic [wb_ic_pkg::DATA_W-1:0]  t_dat_i     [wb_ic_pkg::N_TARGETS],
	output logic                          m_ack_o     [wb_ic_pkg::N_MASTERS],
	output logic                          m_err_o     [wb_ic_pkg::N_MASTERS],
	output logic [wb_ic_pkg::DATA_W-1:0]  m_dat_o     [wb_ic_pkg::N_MASTERS]
);
	import wb_ic_pkg::*;

	logic [N_MASTERS-1:0] err_q;

	always_comb begin
		for (int m = 0; m < N_MASTERS; m++) begin
			m_ack_o[m] = 1'b0;
			m_dat_o[m] = '0;
			for (int t = 0; t < N_TARGETS; t++) begin
				// Only the master that owns the target's grant sees its response
				if (sel_tgt_i[m] == tgt_id_t'(t) && gnt_valid_i[t] &&
						gnt_id_i[t] == mst_id_t'(m)) begin
					m_ack_o[m] = t_ack_i[t];
					m_dat_o[m] = t_dat_i[t];
				end
			end
			m_err_o[m] = err_q[m];
		end
	end

	// Decode-fail responder
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= '0;
		end else begin
			for (int m = 0; m < N_MASTERS; m++) begin
				// Self-clearing, the decoder drops the cycle on the err edge
				err_q[m] <= busy_i[m] && (sel_tgt_i[m] == TGT_NONE) && !err_q[m];
			end
		end
	end

endmodule

// File: wb_ic_arbiter.sv
/*
 * Round-robin arbiter for one target, with the forward mux of the
 * granted master's cycle. One instance sits in front of each RAM.
 */
module wb_ic_arbiter (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic [wb_ic_pkg::N_MASTERS-1:0] req_i,
	input  logic                          m_cyc_i [wb_ic_pkg::N_MASTERS],
	input  logic                          m_stb_i [wb_ic_pkg::N_MASTERS],
	input  logic                          m_we_i  [wb_ic_pkg::N_MASTERS],
	input  logic [wb_ic_pkg::ADDR_W-1:0]  m_adr_i [wb_ic_pkg::N_MASTERS],
	input  logic [wb_ic_pkg::DATA_W-1:0]  m_dat_i [wb_ic_pkg::N_MASTERS],
	input  logic [wb_ic_pkg::SEL_W-1:0]   m_sel_i [wb_ic_pkg::N_MASTERS],
	output logic                          t_cyc_o,
	output logic                          t_stb_o,
	output logic                          t_we_o,
	output logic [wb_ic_pkg::ADDR_W-1:0]  t_adr_o,
	output logic [wb_ic_pkg::DATA_W-1:0]  t_dat_o,
	output logic [wb_ic_pkg::SEL_W-1:0]   t_sel_o,
	output logic                          gnt_valid_o,
	output wb_ic_pkg::mst_id_t            gnt_id_o
);
	import wb_ic_pkg::*;

	arb_state_e state;
	mst_id_t    last_id;
	mst_id_t    pick_id;
	logic       pick_valid;
	logic       fwd;

	always_comb begin
		pick_valid = |req_i;
		pick_id = '0;
		// Lowest requester as the fallback
		for (int i = N_MASTERS - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				pick_id = mst_id_t'(i);
			end
		end
		// First requester above the last winner goes ahead of it
		for (int i = N_MASTERS - 1; i >= 0; i--) begin
			if (req_i[i] && i > int'(last_id)) begin
				pick_id = mst_id_t'(i);
			end
		end
	end

	// last_id doubles as the current grant while busy
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ARB_IDLE;
			// Highest id as last winner so master 0 goes first
			last_id <= mst_id_t'(N_MASTERS - 1);
		end else begin
			case (state)
				ARB_IDLE: begin
					if (pick_valid) begin
						state <= ARB_BUSY;
						last_id <= pick_id;
					end
				end
				ARB_BUSY: begin
					if (!req_i[last_id]) begin
						state <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	assign gnt_valid_o = (state == ARB_BUSY);
	assign gnt_id_o = last_id;

	// Winner's request is already gone in the release cycle, so stop forwarding then
	assign fwd = gnt_valid_o && req_i[last_id];

	always_comb begin
		t_cyc_o = fwd && m_cyc_i[last_id];
		t_stb_o = fwd && m_stb_i[last_id];
		t_we_o  = fwd && m_we_i[last_id];
		t_adr_o = fwd ? m_adr_i[last_id] : '0;
		t_dat_o = fwd ? m_dat_i[last_id] : '0;
		t_sel_o = fwd ? m_sel_i[last_id] : '0;
	end

endmodule

// File: wb_ic_decoder.sv
/*
 * Address decoder and request tracker, one FSM per master.
 * Latches the target window of a new cycle and holds it until the
 * master's own ack or err comes back through done_i.
 */
module wb_ic_decoder (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          cyc_i     [wb_ic_pkg::N_MASTERS],
	input  logic                          stb_i     [wb_ic_pkg::N_MASTERS],
	input  logic [wb_ic_pkg::ADDR_W-1:0]  adr_i     [wb_ic_pkg::N_MASTERS],
	input  logic                          done_i    [wb_ic_pkg::N_MASTERS],
	output wb_ic_pkg::tgt_id_t            sel_tgt_o [wb_ic_pkg::N_MASTERS],
	output logic                          busy_o    [wb_ic_pkg::N_MASTERS]
);
	import wb_ic_pkg::*;

	// Window index is everything above the in-window offset
	function automatic tgt_id_t win_of(logic [ADDR_W-1:0] adr);
		logic [ADDR_W-TGT_WIN_BITS-1:0] win;
		win = adr[ADDR_W-1:TGT_WIN_BITS];
		if (win < N_TARGETS) begin
			return tgt_id_t'(win);
		end
		return TGT_NONE;
	endfunction

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_mst
		dec_state_e state;
		tgt_id_t    sel_q;

		always_ff @(posedge clk) begin
			if (!rstn) begin
				state <= DEC_IDLE;
				sel_q <= TGT_NONE;
			end else begin
				case (state)
					DEC_IDLE: begin
						if (cyc_i[m] && stb_i[m]) begin
							state <= DEC_WAIT;
							sel_q <= win_of(adr_i[m]);
						end
					end
					DEC_WAIT: begin
						// Response seen, free the target for the next cycle
						if (done_i[m]) begin
							state <= DEC_IDLE;
							sel_q <= TGT_NONE;
						end
					end
					default: begin
						state <= DEC_IDLE;
						sel_q <= TGT_NONE;
					end
				endcase
			end
		end

		assign sel_tgt_o[m] = sel_q;
		// Tells the response path that a TGT_NONE selection is a live unmapped cycle
		assign busy_o[m] = (state == DEC_WAIT);
	end

endmodule

// File: wb_ic_pkg.sv
/*
 * Shared constants and types for the two-master Wishbone interconnect.
 * Every interconnect module imports this package, so it compiles first.
 */
package wb_ic_pkg;

	// Bus population
	localparam int N_MASTERS = 2;
	localparam int N_TARGETS = 2;

	// Bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;

	// Each target window spans 4 KiB, anything from 0x2000 up is unmapped
	localparam int TGT_WIN_BITS = 12;

	// RAM geometry, word index taken from address bits above the byte offset
	localparam int RAM_WORDS = 64;
	localparam int RAM_AW = $clog2(RAM_WORDS);

	// Target index, with one code reserved for "no target"
	typedef logic [1:0] tgt_id_t;
	localparam tgt_id_t TGT_NONE = 2'd3;

	// Master index
	typedef logic [0:0] mst_id_t;

	// Per-master request tracking
	typedef enum logic {
		DEC_IDLE,
		DEC_WAIT
	} dec_state_e;

	// Per-target grant state
	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_e;

endpackage
